/* common/zxuno_pkg.sv */
package zxuno_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // I/O port map
   ////////////////////////////////////////////////////////////////////////////

   // Register address port of the ZX-Uno bank, full 16-bit decode
   localparam logic [15:0] ZXUNO_ADDR_PORT = 16'hFC3B;

   // Data port for whichever register is addressed
   localparam logic [15:0] ZXUNO_DATA_PORT = 16'hFD3B;

   // Kempston joystick, low byte only
   localparam logic [7:0]  KEMPSTON_PORT   = 8'h1F;

   // Value seen on reads nobody claims
   localparam logic [7:0]  BUS_IDLE        = 8'hFF;

   ////////////////////////////////////////////////////////////////////////////
   // Register bank
   ////////////////////////////////////////////////////////////////////////////

   // Register numbers reachable through the data port
   typedef enum logic [7:0] {
      REG_JOYCONF = 8'h06,
      REG_COREID  = 8'hFF
   } zxreg_e;

   // Kempston on out of reset
   localparam logic [7:0]  JOYCONF_RESET   = 8'h01;

   ////////////////////////////////////////////////////////////////////////////
   // Core identification
   ////////////////////////////////////////////////////////////////////////////

   // Characters in the ID, terminator not counted
   localparam int          CORE_ID_LEN     = 5;

   // Index runs 0..CORE_ID_LEN, last value selects the 00 terminator
   localparam int          CORE_ID_IDX_W   = $clog2(CORE_ID_LEN + 1);

   // First character sits in the top byte
   localparam logic [8*CORE_ID_LEN-1:0] CORE_ID = "ZXIO1";

   ////////////////////////////////////////////////////////////////////////////
   // Audio mixer levels
   ////////////////////////////////////////////////////////////////////////////

   // Speaker loudest, then EAR, then MIC
   // 128 + 64 + 32 = 224 so the sum never overflows 8 bits
   localparam logic [7:0]  SPK_WEIGHT      = 8'd128;
   localparam logic [7:0]  EAR_WEIGHT      = 8'd64;
   localparam logic [7:0]  MIC_WEIGHT      = 8'd32;

endpackage

/* regbank/zxuno_regs.sv */
`timescale 1ns/1ps

module zxuno_regs
   import zxuno_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic [15:0] a,
   input  logic [7:0]  din,
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   output logic [7:0]  dout,
   output logic        oe_n,
   // To the register clients
   output logic [7:0]  reg_addr,
   output logic        reg_rd,
   output logic        reg_wr
);

   // Raw strobe qualifiers
   logic io_rd;
   logic io_wr;

   // Port decodes
   logic addr_rd_dec;
   logic addr_wr_dec;
   logic data_rd_dec;
   logic data_wr_dec;

   // Previous-clock copies for edge detection
   logic addr_wr_q;
   logic data_wr_q;

   assign io_rd = !iorq_n && !rd_n;
   assign io_wr = !iorq_n && !wr_n;

   // Full 16 bit match on both ports
   assign addr_rd_dec = io_rd && (a == ZXUNO_ADDR_PORT);
   assign addr_wr_dec = io_wr && (a == ZXUNO_ADDR_PORT);
   assign data_rd_dec = io_rd && (a == ZXUNO_DATA_PORT);
   assign data_wr_dec = io_wr && (a == ZXUNO_DATA_PORT);

   ////////////////////////////////////////////////////////////////////////////
   // Address register
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         addr_wr_q <= 1'b0;
         data_wr_q <= 1'b0;
         reg_addr  <= 8'h00;
      end else begin
         addr_wr_q <= addr_wr_dec;
         data_wr_q <= data_wr_dec;
         // Latch only on the first sampled clock of the write
         if (addr_wr_dec && !addr_wr_q) begin
            reg_addr <= din;
         end
      end
   end

   // Address readback
   assign dout = reg_addr;
   assign oe_n = !addr_rd_dec;

   ////////////////////////////////////////////////////////////////////////////
   // Data port strobes
   ////////////////////////////////////////////////////////////////////////////
   // Level for the whole read
   assign reg_rd = data_rd_dec;

   // High until the first edge of the write, then dropped by data_wr_q
   assign reg_wr = data_wr_dec && !data_wr_q;

endmodule

/* regbank/coreid.sv */
`timescale 1ns/1ps

module coreid
   import zxuno_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic [7:0] reg_addr,
   input  logic       reg_rd,
   output logic [7:0] dout,
   output logic       oe_n
);

   // Character pointer, CORE_ID_LEN means terminator
   logic [CORE_ID_IDX_W-1:0] idx;
   logic                     rd_q;
   logic                     sel;
   logic                     last;

   assign sel  = (reg_addr == REG_COREID);
   assign last = (idx == CORE_ID_IDX_W'(CORE_ID_LEN));

   ////////////////////////////////////////////////////////////////////////////
   // Index advance
   ////////////////////////////////////////////////////////////////////////////
   // Step once per completed read, on the clock after reg_rd drops
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_q <= 1'b0;
         idx  <= '0;
      end else begin
         rd_q <= reg_rd;
         if (rd_q && !reg_rd && sel) begin
            // Back to the first char after the 00
            if (last) begin
               idx <= '0;
            end else begin
               idx <= idx + 1'b1;
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Read data
   ////////////////////////////////////////////////////////////////////////////
   // String stored MSB first, so index 0 is the top byte
   assign dout = last ? 8'h00 : CORE_ID[8*(CORE_ID_LEN-1-int'(idx)) +: 8];
   assign oe_n = !(sel && reg_rd);

endmodule

/* rtl/ula_port.sv */
`timescale 1ns/1ps

module ula_port (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [15:0] a,
   input  logic [7:0]  din,
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   input  logic        ear,
   input  logic [4:0]  kbdcol,
   output logic [7:0]  dout,
   output logic        oe_n,
   output logic [2:0]  border,
   output logic        mic,
   output logic        spk
);

   // Any even port is the ULA, A0 low
   logic ula_sel;
   logic wr_dec;
   logic wr_q;

   assign ula_sel = !iorq_n && !a[0];
   assign wr_dec  = ula_sel && !wr_n;

   ////////////////////////////////////////////////////////////////////////////
   // Write latch
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_q   <= 1'b0;
         border <= 3'b000;
         mic    <= 1'b0;
         spk    <= 1'b0;
      end else begin
         wr_q <= wr_dec;
         // One capture per access
         if (wr_dec && !wr_q) begin
            border <= din[2:0];
            mic    <= din[3];
            spk    <= din[4];
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Read value
   ////////////////////////////////////////////////////////////////////////////
   // Bits 7 and 5 float high on the real machine
   assign dout = {1'b1, ear, 1'b1, kbdcol};
   assign oe_n = !(ula_sel && !rd_n);

endmodule

/* rtl/joystick_port.sv */
`timescale 1ns/1ps

module joystick_port
   import zxuno_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic [15:0] a,
   input  logic [7:0]  din,
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic [7:0]  reg_addr,
   input  logic        reg_rd,
   input  logic        reg_wr,
   // DB9 lines, low when pressed
   input  logic        joy_up,
   input  logic        joy_down,
   input  logic        joy_left,
   input  logic        joy_right,
   input  logic        joy_fire,
   output logic [7:0]  dout,
   output logic        oe_n
);

   logic [7:0] joyconf;
   logic       conf_sel;
   logic       conf_rd;
   logic       kemp_rd;
   logic [7:0] kemp_val;

   assign conf_sel = (reg_addr == REG_JOYCONF);
   assign conf_rd  = conf_sel && reg_rd;

   // Upper address byte ignored, Kempston style; bit 0 enables the port
   assign kemp_rd  = !iorq_n && !rd_n && (a[7:0] == KEMPSTON_PORT) && joyconf[0];

   // Config register, written through the data port
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         joyconf <= JOYCONF_RESET;
      end else if (reg_wr && conf_sel) begin
         joyconf <= din;
      end
   end

   // Kempston bit order, active high
   assign kemp_val = {3'b000, ~joy_fire, ~joy_up, ~joy_down, ~joy_left, ~joy_right};

   // Config readback takes precedence, both never overlap on the bus
   assign dout = conf_rd ? joyconf : kemp_val;
   assign oe_n = !(conf_rd || kemp_rd);

endmodule

/* rtl/audio_mixer.sv */
`timescale 1ns/1ps

module audio_mixer
   import zxuno_pkg::*;
(
   input  logic clk,
   input  logic rst_n,
   input  logic mic,
   input  logic spk,
   input  logic ear,
   output logic audio_out
);

   // EAR comes from off chip
   logic       ear_meta;
   logic       ear_sync;
   logic [7:0] level;
   logic [7:0] acc;

   ////////////////////////////////////////////////////////////////////////////
   // Synchronizer and level
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ear_meta <= 1'b0;
         ear_sync <= 1'b0;
         level    <= 8'h00;
      end else begin
         ear_meta <= ear;
         ear_sync <= ear_meta;
         // Weights add without overflow
         level    <= (spk      ? SPK_WEIGHT : 8'h00) +
                     (ear_sync ? EAR_WEIGHT : 8'h00) +
                     (mic      ? MIC_WEIGHT : 8'h00);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // First order sigma-delta
   ////////////////////////////////////////////////////////////////////////////
   // Carry out of the 8-bit accumulator is the pulse density output
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         acc       <= 8'h00;
         audio_out <= 1'b0;
      end else begin
         {audio_out, acc} <= {1'b0, acc} + {1'b0, level};
      end
   end

endmodule

/* rtl/zxuno_io.sv */
`timescale 1ns/1ps

module zxuno_io
   import zxuno_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   // Z80 style I/O bus
   input  logic [15:0] a,
   input  logic [7:0]  din,
   input  logic        iorq_n,
   input  logic        rd_n,
   input  logic        wr_n,
   output logic [7:0]  dout,
   // Tape input and keyboard columns
   input  logic        ear,
   input  logic [4:0]  kbdcol,
   // DB9 joystick, active low
   input  logic        joy_up,
   input  logic        joy_down,
   input  logic        joy_left,
   input  logic        joy_right,
   input  logic        joy_fire,
   // Border colour and audio
   output logic [2:0]  border,
   output logic        audio_out
);

   // Register bank link
   logic [7:0] reg_addr;
   logic       reg_rd;
   logic       reg_wr;

   // Per block read data and enables
   logic [7:0] regs_dout;
   logic       regs_oe_n;
   logic [7:0] coreid_dout;
   logic       coreid_oe_n;
   logic [7:0] joy_dout;
   logic       joy_oe_n;
   logic [7:0] ula_dout;
   logic       ula_oe_n;

   // ULA sound sources to mixer
   logic       mic;
   logic       spk;

   ////////////////////////////////////////////////////////////////////////////
   // Register address / data port pair
   ////////////////////////////////////////////////////////////////////////////
   zxuno_regs u_zxuno_regs (
      .clk      (clk),
      .rst_n    (rst_n),
      .a        (a),
      .din      (din),
      .iorq_n   (iorq_n),
      .rd_n     (rd_n),
      .wr_n     (wr_n),
      .dout     (regs_dout),
      .oe_n     (regs_oe_n),
      .reg_addr (reg_addr),
      .reg_rd   (reg_rd),
      .reg_wr   (reg_wr)
   );

   // ID string, a client of the bank
   coreid u_coreid (
      .clk      (clk),
      .rst_n    (rst_n),
      .reg_addr (reg_addr),
      .reg_rd   (reg_rd),
      .dout     (coreid_dout),
      .oe_n     (coreid_oe_n)
   );

   // Kempston port plus its config register
   joystick_port u_joystick_port (
      .clk       (clk),
      .rst_n     (rst_n),
      .a         (a),
      .din       (din),
      .iorq_n    (iorq_n),
      .rd_n      (rd_n),
      .reg_addr  (reg_addr),
      .reg_rd    (reg_rd),
      .reg_wr    (reg_wr),
      .joy_up    (joy_up),
      .joy_down  (joy_down),
      .joy_left  (joy_left),
      .joy_right (joy_right),
      .joy_fire  (joy_fire),
      .dout      (joy_dout),
      .oe_n      (joy_oe_n)
   );

   // Port FE
   ula_port u_ula_port (
      .clk    (clk),
      .rst_n  (rst_n),
      .a      (a),
      .din    (din),
      .iorq_n (iorq_n),
      .rd_n   (rd_n),
      .wr_n   (wr_n),
      .ear    (ear),
      .kbdcol (kbdcol),
      .dout   (ula_dout),
      .oe_n   (ula_oe_n),
      .border (border),
      .mic    (mic),
      .spk    (spk)
   );

   // One bit DAC
   audio_mixer u_audio_mixer (
      .clk       (clk),
      .rst_n     (rst_n),
      .mic       (mic),
      .spk       (spk),
      .ear       (ear),
      .audio_out (audio_out)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Read data priority mux
   ////////////////////////////////////////////////////////////////////////////
   // First enabled block wins, bank port checked first
   assign dout = (!regs_oe_n)   ? regs_dout   :
                 (!coreid_oe_n) ? coreid_dout :
                 (!joy_oe_n)    ? joy_dout    :
                 (!ula_oe_n)    ? ula_dout    :
                                  BUS_IDLE;

endmodule

/* dv/tb_zxuno_io.sv */
`timescale 1ns/1ps

module tb_zxuno_io
   import zxuno_pkg::*;
();

   logic        clk;
   logic        rst_n;
   logic [15:0] a;
   logic [7:0]  din;
   logic        iorq_n;
   logic        rd_n;
   logic        wr_n;
   logic [7:0]  dout;
   logic        ear;
   logic [4:0]  kbdcol;
   logic        joy_up;
   logic        joy_down;
   logic        joy_left;
   logic        joy_right;
   logic        joy_fire;
   logic [2:0]  border;
   logic        audio_out;

   // Reference model state
   logic [7:0]  m_reg_addr;
   logic [7:0]  m_joyconf;
   int          m_core_idx;
   logic [2:0]  m_border;
   logic        m_mic;
   logic        m_spk;
   int          error_count;

   // ID text Z X I O 1, terminator handled separately
   logic [7:0]  id_chars [0:4] = '{8'h5A, 8'h58, 8'h49, 8'h4F, 8'h31};

   // Pending comparisons, popped by the compare process
   string       name_q [$];
   logic [31:0] got_q [$];
   logic [31:0] want_q [$];

   zxuno_io u_zxuno_io (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////////////
   // Expected read value, same priority as the bus mux
   function automatic logic [7:0] expected_read(input logic [15:0] addr);
      logic [7:0] val;
      if (addr == 16'hFC3B) begin
         return m_reg_addr;
      end else if (addr == 16'hFD3B && m_reg_addr == 8'hFF) begin
         return (m_core_idx < 5) ? id_chars[m_core_idx] : 8'h00;
      end else if (addr == 16'hFD3B && m_reg_addr == 8'h06) begin
         return m_joyconf;
      end else if (addr[7:0] == 8'h1F && m_joyconf[0]) begin
         // Pressed button reads as 1, top three bits clear
         val    = 8'h00;
         val[0] = !joy_right;
         val[1] = !joy_left;
         val[2] = !joy_down;
         val[3] = !joy_up;
         val[4] = !joy_fire;
         return val;
      end else if (!addr[0]) begin
         // Bits 7 and 5 always set
         val      = 8'hA0;
         val[6]   = ear;
         val[4:0] = kbdcol;
         return val;
      end
      // Nobody claims it
      return 8'hFF;
   endfunction

   // Spk 128, ear 64, mic 32
   function automatic int expected_level(input logic s, input logic m, input logic e);
      return (s ? 128 : 0) + (e ? 64 : 0) + (m ? 32 : 0);
   endfunction

   // Register side effects of a write
   task automatic model_write(input logic [15:0] addr, input logic [7:0] data);
      if (addr == 16'hFC3B) begin
         m_reg_addr = data;
      end else if (addr == 16'hFD3B && m_reg_addr == 8'h06) begin
         m_joyconf = data;
      end
      if (!addr[0]) begin
         m_border = data[2:0];
         m_mic    = data[3];
         m_spk    = data[4];
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Checking
   ////////////////////////////////////////////////////////////////////////////
   task automatic check_equal(input string name, input logic [31:0] got,
                              input logic [31:0] want);
      if (got !== want) begin
         error_count++;
         $display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, want);
         $display("*** FAILED ***");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   task automatic queue_compare(input string name, input logic [31:0] got,
                                input logic [31:0] want);
      name_q.push_back(name);
      got_q.push_back(got);
      want_q.push_back(want);
   endtask

   // Compare process
   always @(posedge clk) begin
      while (got_q.size() > 0) begin
         check_equal(name_q.pop_front(), got_q.pop_front(), want_q.pop_front());
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Bus accesses, 3 active cycles then 2 idle
   ////////////////////////////////////////////////////////////////////////////
   task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
      @(posedge clk);
      a      <= addr;
      din    <= data;
      iorq_n <= 1'b0;
      wr_n   <= 1'b0;
      repeat (3) @(posedge clk);
      iorq_n <= 1'b1;
      wr_n   <= 1'b1;
      repeat (2) @(posedge clk);
      model_write(addr, data);
   endtask

   task automatic io_read(input logic [15:0] addr, input string name);
      logic [7:0] want;
      @(posedge clk);
      a      <= addr;
      iorq_n <= 1'b0;
      rd_n   <= 1'b0;
      repeat (2) @(posedge clk);
      // Last active cycle, away from the edge
      @(negedge clk);
      want = expected_read(addr);
      queue_compare(name, 32'(dout), 32'(want));
      @(posedge clk);
      iorq_n <= 1'b1;
      rd_n   <= 1'b1;
      repeat (2) @(posedge clk);
      // ID pointer steps after each completed read
      if (addr == 16'hFD3B && m_reg_addr == 8'hFF) begin
         m_core_idx = (m_core_idx == 5) ? 0 : m_core_idx + 1;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      logic [7:0]  data;
      logic [2:0]  combo;
      int          count;
      int          waited;
      void'($urandom(32'h511));
      error_count = 0;
      m_reg_addr  = 8'h00;
      m_joyconf   = 8'h01;
      m_core_idx  = 0;
      m_border    = 3'b000;
      m_mic       = 1'b0;
      m_spk       = 1'b0;
      rst_n       = 1'b0;
      a           = 16'h0000;
      din         = 8'h00;
      iorq_n      = 1'b1;
      rd_n        = 1'b1;
      wr_n        = 1'b1;
      ear         = 1'b0;
      kbdcol      = 5'h1F;
      {joy_up, joy_down, joy_left, joy_right, joy_fire} = 5'h1F;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      repeat (2) @(posedge clk);

      // Address port, reset value then random
      io_read(ZXUNO_ADDR_PORT, "reg_addr");
      repeat (6) begin
         io_write(ZXUNO_ADDR_PORT, 8'($urandom()));
         io_read(ZXUNO_ADDR_PORT, "reg_addr");
      end

      // Core ID twice round, terminator included
      io_write(ZXUNO_ADDR_PORT, 8'hFF);
      repeat (12) io_read(ZXUNO_DATA_PORT, "coreid");

      // Kempston with random buttons and upper address byte
      repeat (8) begin
         @(posedge clk);
         {joy_up, joy_down, joy_left, joy_right, joy_fire} <= 5'($urandom());
         io_read({8'($urandom()), KEMPSTON_PORT}, "kempston");
      end
      io_write(ZXUNO_ADDR_PORT, 8'h06);
      io_read(ZXUNO_DATA_PORT, "joyconf");
      io_write(ZXUNO_DATA_PORT, 8'h00);
      // Disabled port falls through to idle
      io_read({8'($urandom()), KEMPSTON_PORT}, "kempston_off");
      io_read(ZXUNO_DATA_PORT, "joyconf");

      // ULA writes then reads
      repeat (6) begin
         data = 8'($urandom());
         io_write({8'($urandom()), 8'hFE}, data);
         queue_compare("border", 32'(border), 32'(m_border));
      end
      repeat (6) begin
         @(posedge clk);
         ear    <= 1'($urandom());
         kbdcol <= 5'($urandom());
         io_read({8'($urandom()), 8'hFE}, "ula_dout");
      end
      io_read(16'h00FF, "idle_bus");

      // Mixer, pulse count over one accumulator period
      repeat (8) begin
         combo = 3'($urandom());
         io_write(16'h00FE, {3'b000, combo[2], combo[1], 3'($urandom())});
         @(posedge clk);
         ear <= combo[0];
         repeat (8) @(posedge clk);
         count = 0;
         repeat (256) begin
            @(negedge clk);
            if (audio_out) begin
               count++;
            end
         end
         queue_compare("audio_out_count", 32'(count),
                       32'(expected_level(m_spk, m_mic, ear)));
      end

      // Let the compare process catch up
      waited = 0;
      while (got_q.size() != 0 && waited < 50) begin
         @(posedge clk);
         waited++;
      end
      if (got_q.size() != 0) begin
         $display("Compare queue still holds results after the drain timeout");
         $display("*** FAILED ***");
         $fatal(1, "Drain timeout");
      end
      if (error_count == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

/* compile.f */
common/zxuno_pkg.sv
regbank/zxuno_regs.sv
regbank/coreid.sv
rtl/ula_port.sv
rtl/joystick_port.sv
rtl/audio_mixer.sv
rtl/zxuno_io.sv
dv/tb_zxuno_io.sv

/* Makefile */
VERILATOR  ?= verilator
VFLAGS     := --binary --timing
LINT_FLAGS := --lint-only -Wall --timing
TOP        := tb_zxuno_io
RTL_TOP    := zxuno_io
FILELIST   := compile.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -F -q "*** PASSED ***" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
